// ==== all.f ====
design/dlx_isa_pkg.sv
design/dlx_pipe_pkg.sv
design/fetch_stage.sv
design/reg_file.sv
design/decode_stage.sv
design/hazard_unit.sv
design/execute_stage.sv
design/write_back_stage.sv
design/dlx_core.sv
bench/dlx_checker.sv
bench/tb_dlx_core.sv

// ==== bench/dlx_checker.sv ====
// --------------------------------------------------
// dlx isa reference model, data-store comparison
// reset and first-fetch checks at the core ports
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module dlx_checker
   import dlx_isa_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   input  logic  instr_rd_en,
   input  pc_t   instr_addr,
   input  logic  data_rd_en,
   input  logic  data_wr_en,
   input  data_t data_addr,
   input  data_t data_write,
   input  data_t imem_image [128],
   input  data_t dmem_image [256],
   output int    error_count,
   output int    store_count,
   output int    expected_count,
   output logic  stores_done
);

   localparam int step_limit = 1000;

   data_t exp_addr [$];
   data_t exp_data [$];
   logic  model_ready;
   logic  fetch_seen;

   // --------------------------------------------------
   // isa model, runs until the self branch
   // --------------------------------------------------
   task automatic run_model();
      data_t      regs [32];
      data_t      mem [256];
      data_t      instr;
      data_t      a;
      data_t      b;
      data_t      imm;
      data_t      res;
      data_t      addr;
      pc_t        pc;
      pc_t        next_pc;
      int         steps;
      logic       parked;
      logic       wr;
      logic [4:0] rd;
      for (int i = 0; i < 32; i++) begin
         regs[i] = '0;
      end
      for (int i = 0; i < 256; i++) begin
         mem[i] = dmem_image[i];
      end
      exp_addr.delete();
      exp_data.delete();
      pc     = pc_reset;
      steps  = 0;
      parked = 1'b0;
      while (!parked && steps < step_limit) begin
         instr   = imem_image[pc[8:2]];
         a       = regs[instr[25:21]];
         b       = regs[instr[20:16]];
         imm     = {{16{instr[15]}}, instr[15:0]};
         res     = '0;
         wr      = 1'b0;
         rd      = instr[20:16];
         next_pc = pc + 20'd4;
         case (instr[31:26])
            op_rtype: begin
               wr = 1'b1;
               rd = instr[15:11];
               case (instr[5:0])
                  fn_add:  res = a + b;
                  fn_sub:  res = a - b;
                  fn_and:  res = a & b;
                  fn_or:   res = a | b;
                  fn_xor:  res = a ^ b;
                  fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default: wr = 1'b0;
               endcase
            end
            op_addi: begin
               wr  = 1'b1;
               res = a + imm;
            end
            op_lw: begin
               wr   = 1'b1;
               addr = a + imm;
               res  = mem[addr[9:2]];
            end
            op_sw: begin
               addr = a + imm;
               mem[addr[9:2]] = b;
               exp_addr.push_back(addr);
               exp_data.push_back(b);
            end
            op_beqz, op_bnez: begin
               // beqz wants rs1 zero, bnez non-zero
               if ((a == '0) == (instr[31:26] == op_beqz)) begin
                  next_pc = pc + 20'd4 + imm[19:0];
                  parked  = (next_pc == pc);
               end
            end
            default: ;
         endcase
         // r0 stays zero
         if (wr && rd != '0) begin
            regs[rd] = res;
         end
         pc = next_pc;
         steps++;
      end
      expected_count = exp_addr.size();
      model_ready    = 1'b1;
   endtask

   initial begin
      error_count    = 0;
      store_count    = 0;
      expected_count = 0;
      model_ready    = 1'b0;
      fetch_seen     = 1'b0;
   end

   // images are complete before reset is released
   always @(posedge arst_n) begin
      run_model();
   end

   assign stores_done = model_ready && (store_count >= expected_count);

   // --------------------------------------------------
   // port checks
   // --------------------------------------------------
   always @(posedge clk) begin
      if (!arst_n) begin
         if (instr_rd_en || data_rd_en || data_wr_en) begin
            $display("[ERROR] %0t: memory enable high during reset", $time);
            error_count++;
         end
      end else begin
         if (instr_rd_en && !fetch_seen) begin
            fetch_seen = 1'b1;
            if (instr_addr !== pc_reset) begin
               $display("[ERROR] %0t: first fetch at %h, expected %h",
                        $time, instr_addr, pc_reset);
               error_count++;
            end
         end
         if (data_wr_en && data_rd_en) begin
            $display("[ERROR] %0t: store and load in the same cycle", $time);
            error_count++;
         end
         if (data_wr_en) begin
            if (store_count >= expected_count) begin
               $display("[ERROR] %0t: extra store %h to %h, only %0d expected",
                        $time, data_write, data_addr, expected_count);
               error_count++;
            end else if (data_addr !== exp_addr[store_count] ||
                         data_write !== exp_data[store_count]) begin
               $display("[ERROR] %0t: store %0d wrote %h to %h, expected %h to %h",
                        $time, store_count, data_write, data_addr,
                        exp_data[store_count], exp_addr[store_count]);
               error_count++;
            end
            store_count++;
         end
      end
   end

endmodule

`default_nettype wire

// ==== bench/tb_dlx_core.sv ====
// --------------------------------------------------
// dlx_core testbench top: clock, reset, lcg stimulus
// random program, instruction and data memory models
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_dlx_core
   import dlx_isa_pkg::*;
();

   localparam int prog_len       = 64;
   localparam int imem_words     = 128;
   localparam int dmem_words     = 256;
   localparam int seed           = 26572;
   localparam int timeout_cycles = 2000;
   localparam int drain_cycles   = 20;

   logic  clk;
   logic  arst_n;
   logic  instr_rd_en;
   pc_t   instr_addr;
   data_t instruction;
   logic  data_rd_en;
   logic  data_wr_en;
   data_t data_addr;
   data_t data_read;
   data_t data_write;

   // memory images
   // dmem_init keeps the starting data for the model
   data_t       imem [imem_words];
   data_t       dmem [dmem_words];
   data_t       dmem_init [dmem_words];
   data_t       imem_q;
   data_t       dmem_q;
   logic [31:0] lcg_state;
   int          error_count;
   int          store_count;
   int          expected_count;
   logic        stores_done;
   int          cycles;
   logic        timed_out;

   // --------------------------------------------------
   // random program
   // --------------------------------------------------
   // result is the upper half of the state
   function automatic logic [15:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[31:16];
   endfunction

   function automatic data_t enc_r(func_e fn, int rd, int rs1, int rs2);
      return {op_rtype, 5'(rs1), 5'(rs2), 5'(rd), 5'd0, fn};
   endfunction

   // rd slot also holds the store data register of sw
   function automatic data_t enc_i(opcode_e op, int rd, int rs1, logic [15:0] imm);
      return {op, 5'(rs1), 5'(rd), imm};
   endfunction

   function automatic data_t rand_instr();
      int          kind;
      int          rd;
      int          rs1;
      int          rs2;
      func_e       fn;
      logic [15:0] addr;
      data_t       instr;
      kind = next_rand() % 16;
      // only r0..r7 for frequent dependencies
      rd   = next_rand() % 8;
      rs1  = next_rand() % 8;
      rs2  = next_rand() % 8;
      // r0 plus word-aligned offset below 1024
      addr = 16'(4 * (next_rand() % 256));
      case (next_rand() % 6)
         0:       fn = fn_add;
         1:       fn = fn_sub;
         2:       fn = fn_and;
         3:       fn = fn_or;
         4:       fn = fn_xor;
         default: fn = fn_slt;
      endcase
      if (kind < 6) begin
         instr = enc_r(fn, rd, rs1, rs2);
      end else if (kind < 9) begin
         instr = enc_i(op_addi, rd, rs1, next_rand());
      end else if (kind < 11) begin
         instr = enc_i(op_lw, rd, 0, addr);
      end else if (kind < 13) begin
         instr = enc_i(op_sw, rd, 0, addr);
      end else begin
         // forward branch over 1 to 4 instructions
         instr = enc_i(kind < 15 ? op_beqz : op_bnez, 0, rs1,
                       16'(4 * (1 + next_rand() % 4)));
      end
      return instr;
   endfunction

   task automatic build_images();
      lcg_state = seed;
      // zero words decode as bubbles past the program
      for (int i = 0; i < imem_words; i++) begin
         imem[i] = '0;
      end
      for (int i = 0; i < prog_len; i++) begin
         imem[i] = rand_instr();
      end
      // dump r1..r7 at the end
      for (int r = 1; r < 8; r++) begin
         imem[prog_len + r - 1] = enc_i(op_sw, r, 0, 16'(4 * (240 + r)));
      end
      // park on a branch to itself
      imem[prog_len + 7] = enc_i(op_beqz, 0, 0, 16'hfffc);
      for (int i = 0; i < dmem_words; i++) begin
         dmem_init[i] = {next_rand(), next_rand()};
         dmem[i]      = dmem_init[i];
      end
   endtask

   // --------------------------------------------------
   // memory models
   // --------------------------------------------------
   // address taken on the rising edge
   always @(posedge clk) begin
      if (instr_rd_en) begin
         imem_q <= imem[instr_addr[8:2]];
      end
      if (data_rd_en) begin
         dmem_q <= dmem[data_addr[9:2]];
      end
      if (data_wr_en) begin
         dmem[data_addr[9:2]] <= data_write;
      end
   end

   // read data handed to the core half a cycle later
   always @(negedge clk) begin
      instruction <= imem_q;
      data_read   <= dmem_q;
   end

   dlx_core dut_i (.*);

   dlx_checker checker_i (
      .clk            (clk),
      .arst_n         (arst_n),
      .instr_rd_en    (instr_rd_en),
      .instr_addr     (instr_addr),
      .data_rd_en     (data_rd_en),
      .data_wr_en     (data_wr_en),
      .data_addr      (data_addr),
      .data_write     (data_write),
      .imem_image     (imem),
      .dmem_image     (dmem_init),
      .error_count    (error_count),
      .store_count    (store_count),
      .expected_count (expected_count),
      .stores_done    (stores_done)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      arst_n      = 1'b0;
      instruction = '0;
      data_read   = '0;
      imem_q      = '0;
      dmem_q      = '0;
      timed_out   = 1'b0;
      build_images();
      repeat (5) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      // wait for the expected store stream
      cycles = 0;
      while (!stores_done && cycles < timeout_cycles) begin
         @(negedge clk);
         cycles++;
      end
      if (!stores_done) begin
         timed_out = 1'b1;
         $display("timeout: only %0d of %0d expected stores seen after %0d cycles",
                  store_count, expected_count, cycles);
      end else begin
         // catch stores beyond the expected stream
         repeat (drain_cycles) @(negedge clk);
      end
      $display("errors %0d, timeouts %0d, stores %0d of %0d expected",
               error_count, timed_out, store_count, expected_count);
      if (error_count == 0 && !timed_out) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
// -----------------------------------------------
// field split, control decode, immediate extension
// id/ex register with bubble insertion
// -----------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module decode_stage
   import dlx_isa_pkg::*;
   import dlx_pipe_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  data_t     if_instr,
   input  pc_t       if_next_pc,
   input  logic      if_valid,
   input  logic      stall,
   input  logic      flush,
   output reg_addr_t rs1,
   output reg_addr_t rs2,
   input  data_t     rd_data_a,
   input  data_t     rd_data_b,
   output id_ex_t    id_ex
);

   opcode_e opcode;
   func_e   func;
   data_t   imm_ext;
   logic    known;
   id_ex_t  id_next;

   assign opcode = opcode_e'(if_instr[opcode_lsb +: opcode_width]);
   assign func   = func_e'(if_instr[func_width-1:0]);
   // rs2 also names the store data register of sw
   assign rs1    = if_instr[rs1_lsb +: reg_addr_width];
   assign rs2    = if_instr[rs2_lsb +: reg_addr_width];

   assign imm_ext = {{(data_width-imm_width){if_instr[imm_width-1]}},
                     if_instr[imm_width-1:0]};

   // -----------------------------------------------
   // control decode
   // -----------------------------------------------
   always_comb begin
      id_next         = '0;
      id_next.alu_op  = alu_add;
      id_next.imm     = imm_ext;
      id_next.a       = rd_data_a;
      id_next.b       = rd_data_b;
      id_next.rs1     = rs1;
      id_next.rs2     = rs2;
      // i-type destination sits in the rs2 slot
      id_next.rd      = rs2;
      id_next.next_pc = if_next_pc;
      known           = 1'b1;
      case (opcode)
         op_rtype: begin
            id_next.rd        = if_instr[rd_lsb +: reg_addr_width];
            id_next.reg_wr_en = 1'b1;
            case (func)
               fn_add:  id_next.alu_op = alu_add;
               fn_sub:  id_next.alu_op = alu_sub;
               fn_and:  id_next.alu_op = alu_and;
               fn_or:   id_next.alu_op = alu_or;
               fn_xor:  id_next.alu_op = alu_xor;
               fn_slt:  id_next.alu_op = alu_slt;
               default: known = 1'b0;
            endcase
         end
         op_addi: begin
            id_next.use_imm   = 1'b1;
            id_next.reg_wr_en = 1'b1;
         end
         // address = rs1 + imm on the add path
         op_lw: begin
            id_next.use_imm   = 1'b1;
            id_next.reg_wr_en = 1'b1;
            id_next.mem_rd_en = 1'b1;
         end
         op_sw: begin
            id_next.use_imm   = 1'b1;
            id_next.mem_wr_en = 1'b1;
         end
         op_beqz: begin
            id_next.is_branch      = 1'b1;
            id_next.branch_on_zero = 1'b1;
         end
         op_bnez: begin
            id_next.is_branch = 1'b1;
         end
         default: known = 1'b0;
      endcase
      // empty slot or unknown opcode turns into a bubble
      id_next.valid = if_valid && known;
      if (!id_next.valid) begin
         id_next.reg_wr_en = 1'b0;
         id_next.mem_rd_en = 1'b0;
         id_next.mem_wr_en = 1'b0;
         id_next.is_branch = 1'b0;
      end
   end

   // -----------------------------------------------
   // id/ex register
   // -----------------------------------------------
   // bubble on load-use stall or branch flush
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         id_ex <= '0;
      end else if (stall || flush) begin
         id_ex <= '0;
      end else begin
         id_ex <= id_next;
      end
   end

endmodule

`default_nettype wire

// ==== design/dlx_core.sv ====
// -----------------------------------------------
// dlx_core top level, five-stage integer pipeline
// stages, hazard unit and memory ports
// -----------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module dlx_core
   import dlx_isa_pkg::*;
   import dlx_pipe_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   // instruction memory, synchronous read
   output logic  instr_rd_en,
   output pc_t   instr_addr,
   input  data_t instruction,
   // data memory, synchronous read
   output logic  data_rd_en,
   output logic  data_wr_en,
   output data_t data_addr,
   input  data_t data_read,
   output data_t data_write
);

   // if/id
   data_t     if_instr;
   pc_t       if_next_pc;
   logic      if_valid;
   // decode register reads
   reg_addr_t rs1;
   reg_addr_t rs2;
   data_t     rd_data_a;
   data_t     rd_data_b;
   // pipeline registers
   id_ex_t    id_ex;
   ex_mem_t   ex_mem;
   mem_wb_t   mem_wb;
   wb_t       wb;
   // hazard control
   logic      stall;
   logic      flush;
   fwd_sel_e  fwd_a;
   fwd_sel_e  fwd_b;
   redirect_t redirect;

   fetch_stage fetch_i (.*);

   reg_file reg_file_i (
      .rd_addr_a (rs1),
      .rd_addr_b (rs2),
      .*
   );

   decode_stage decode_i (.*);

   hazard_unit hazard_i (.*);

   execute_stage execute_i (.*);

   write_back_stage write_back_i (.*);

   // memory stage is the external data memory
   assign data_rd_en = ex_mem.mem_rd_en;
   assign data_wr_en = ex_mem.mem_wr_en;
   assign data_addr  = ex_mem.alu_data;
   assign data_write = ex_mem.store_data;

endmodule

`default_nettype wire

// ==== design/dlx_isa_pkg.sv ====
// -----------------------------------------------
// dlx instruction set widths and field positions
// opcode, function and alu operation enums
// -----------------------------------------------
`default_nettype none

package dlx_isa_pkg;

   // -----------------------------------------------
   // datapath widths
   // -----------------------------------------------
   localparam int data_width     = 32;
   localparam int pc_width       = 20;
   localparam int reg_addr_width = 5;
   localparam int imm_width      = 16;
   localparam int opcode_width   = 6;
   localparam int func_width     = 6;
   localparam int alu_op_width   = 3;

   // lsb of each instruction field
   localparam int opcode_lsb = 26;
   localparam int rs1_lsb    = 21;
   localparam int rs2_lsb    = 16;
   localparam int rd_lsb     = 11;

   typedef logic [data_width-1:0]     data_t;
   typedef logic [pc_width-1:0]       pc_t;
   typedef logic [reg_addr_width-1:0] reg_addr_t;

   // first fetch address out of reset
   localparam pc_t pc_reset = '0;

   // major opcode
   // r-type picks its operation from func below
   typedef enum logic [opcode_width-1:0] {
      op_rtype = 6'h00,
      op_beqz  = 6'h04,
      op_bnez  = 6'h05,
      op_addi  = 6'h08,
      op_lw    = 6'h23,
      op_sw    = 6'h2b
   } opcode_e;

   // r-type function field, bits 5:0
   typedef enum logic [func_width-1:0] {
      fn_add = 6'h20,
      fn_sub = 6'h22,
      fn_and = 6'h24,
      fn_or  = 6'h25,
      fn_xor = 6'h26,
      fn_slt = 6'h2a
   } func_e;

   // alu operation picked in decode
   typedef enum logic [alu_op_width-1:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_slt
   } alu_op_e;

endpackage

`default_nettype wire

// ==== design/dlx_pipe_pkg.sv ====
// -----------------------------------------------
// pipeline register structs and forwarding select
// -----------------------------------------------
`default_nettype none

package dlx_pipe_pkg;
   import dlx_isa_pkg::*;

   // operand source picked by the hazard unit
   typedef enum logic [1:0] {
      fwd_none,
      fwd_ex_mem,
      fwd_mem_wb
   } fwd_sel_e;

   // id/ex register
   typedef struct packed {
      logic      valid;
      alu_op_e   alu_op;
      logic      use_imm;
      data_t     imm;
      data_t     a;
      data_t     b;
      reg_addr_t rs1;
      reg_addr_t rs2;
      reg_addr_t rd;
      logic      reg_wr_en;
      logic      mem_rd_en;
      logic      mem_wr_en;
      logic      is_branch;
      // beqz when set, bnez when clear
      logic      branch_on_zero;
      pc_t       next_pc;
   } id_ex_t;

   // ex/mem register
   // its fields also drive the data ports
   typedef struct packed {
      data_t     alu_data;
      data_t     store_data;
      reg_addr_t rd;
      logic      reg_wr_en;
      logic      mem_rd_en;
      logic      mem_wr_en;
   } ex_mem_t;

   // mem/wb register
   typedef struct packed {
      data_t     alu_data;
      reg_addr_t rd;
      logic      reg_wr_en;
      logic      mem_to_reg;
   } mem_wb_t;

   // register file write port
   typedef struct packed {
      reg_addr_t rd;
      logic      wr_en;
      data_t     data;
   } wb_t;

   // taken branch back to fetch
   typedef struct packed {
      logic take;
      pc_t  target;
   } redirect_t;

endpackage

`default_nettype wire

// ==== design/execute_stage.sv ====
// -----------------------------------------------
// forwarding muxes, alu, branch resolution
// ex/mem register
// -----------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module execute_stage
   import dlx_isa_pkg::*;
   import dlx_pipe_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  id_ex_t    id_ex,
   input  fwd_sel_e  fwd_a,
   input  fwd_sel_e  fwd_b,
   input  wb_t       wb,
   output ex_mem_t   ex_mem,
   output redirect_t redirect
);

   data_t op_a;
   data_t op_b;
   data_t alu_b;
   data_t alu_res;

   function automatic data_t fwd_pick(fwd_sel_e sel, data_t own, data_t em, data_t wbd);
      data_t val;
      case (sel)
         fwd_ex_mem: val = em;
         fwd_mem_wb: val = wbd;
         default:    val = own;
      endcase
      return val;
   endfunction

   // -----------------------------------------------
   // operands and alu
   // -----------------------------------------------
   assign op_a  = fwd_pick(fwd_a, id_ex.a, ex_mem.alu_data, wb.data);
   // forwarded b is also the store data
   assign op_b  = fwd_pick(fwd_b, id_ex.b, ex_mem.alu_data, wb.data);
   assign alu_b = id_ex.use_imm ? id_ex.imm : op_b;

   always_comb begin
      case (id_ex.alu_op)
         alu_sub: alu_res = op_a - alu_b;
         alu_and: alu_res = op_a & alu_b;
         alu_or:  alu_res = op_a | alu_b;
         alu_xor: alu_res = op_a ^ alu_b;
         alu_slt: alu_res = data_t'($signed(op_a) < $signed(alu_b));
         // add, and load/store address
         default: alu_res = op_a + alu_b;
      endcase
   end

   // beqz / bnez test forwarded rs1
   // target is branch pc + 4 + imm
   always_comb begin
      redirect.take   = id_ex.valid && id_ex.is_branch &&
                        ((op_a == '0) == id_ex.branch_on_zero);
      redirect.target = id_ex.next_pc + id_ex.imm[pc_width-1:0];
   end

   // -----------------------------------------------
   // ex/mem register
   // -----------------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ex_mem <= '0;
      end else begin
         ex_mem.alu_data   <= alu_res;
         ex_mem.store_data <= op_b;
         ex_mem.rd         <= id_ex.rd;
         ex_mem.reg_wr_en  <= id_ex.reg_wr_en;
         ex_mem.mem_rd_en  <= id_ex.mem_rd_en;
         ex_mem.mem_wr_en  <= id_ex.mem_wr_en;
      end
   end

   // decode never marks one instruction as both load and store
   a_rd_wr_excl : assert property (@(posedge clk) disable iff (!arst_n)
                                   !(ex_mem.mem_rd_en && ex_mem.mem_wr_en))
      else $error("data read and write in the same cycle");

endmodule

`default_nettype wire

// ==== design/fetch_stage.sv ====
// -----------------------------------------------
// program counter, fetch address mux, if/id register
// -----------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module fetch_stage
   import dlx_isa_pkg::*;
   import dlx_pipe_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  logic      stall,
   input  logic      flush,
   input  redirect_t redirect,
   input  data_t     instruction,
   output logic      instr_rd_en,
   output pc_t       instr_addr,
   output data_t     if_instr,
   output pc_t       if_next_pc,
   output logic      if_valid
);

   // next sequential address
   pc_t  pc_q;
   // address whose word is arriving this cycle
   pc_t  fetch_pc_q;
   logic fetch_valid_q;
   logic rd_en_q;
   pc_t  fetch_addr;

   // taken branch goes straight to the memory
   // on stall the word in flight is lost, so fetch it again
   always_comb begin
      if (redirect.take) begin
         fetch_addr = redirect.target;
      end else if (stall) begin
         fetch_addr = fetch_pc_q;
      end else begin
         fetch_addr = pc_q;
      end
   end

   assign instr_addr  = fetch_addr;
   assign instr_rd_en = rd_en_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_en_q       <= 1'b0;
         fetch_valid_q <= 1'b0;
         pc_q          <= pc_reset;
         fetch_pc_q    <= pc_reset;
      end else begin
         rd_en_q       <= 1'b1;
         fetch_valid_q <= rd_en_q;
         // pc stays put until the first fetch is issued
         if (rd_en_q) begin
            pc_q       <= fetch_addr + pc_t'(4);
            fetch_pc_q <= fetch_addr;
         end
      end
   end

   // -----------------------------------------------
   // if/id register
   // -----------------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         if_valid <= 1'b0;
      end else if (flush) begin
         // drop the word in flight
         if_valid <= 1'b0;
      end else if (!stall) begin
         if_valid <= fetch_valid_q;
      end
   end

   // word and its pc + 4
   always_ff @(posedge clk) begin
      if (!stall) begin
         if_instr   <= instruction;
         if_next_pc <= fetch_pc_q + pc_t'(4);
      end
   end

endmodule

`default_nettype wire

// ==== design/hazard_unit.sv ====
// -----------------------------------------------
// load-use stall, branch flush, forwarding selects
// -----------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module hazard_unit
   import dlx_isa_pkg::*;
   import dlx_pipe_pkg::*;
(
   input  reg_addr_t rs1,
   input  reg_addr_t rs2,
   input  id_ex_t    id_ex,
   input  ex_mem_t   ex_mem,
   input  mem_wb_t   mem_wb,
   input  redirect_t redirect,
   output logic      stall,
   output logic      flush,
   output fwd_sel_e  fwd_a,
   output fwd_sel_e  fwd_b
);

   // youngest writer of src wins
   function automatic fwd_sel_e pick_fwd(reg_addr_t src, ex_mem_t em, mem_wb_t mw);
      fwd_sel_e sel;
      sel = fwd_none;
      if (mw.reg_wr_en && mw.rd != '0 && mw.rd == src) begin
         sel = fwd_mem_wb;
      end
      if (em.reg_wr_en && em.rd != '0 && em.rd == src) begin
         sel = fwd_ex_mem;
      end
      return sel;
   endfunction

   // load in execute feeding an instruction in decode
   // the load sits in mem/wb one cycle later
   assign stall = id_ex.valid && id_ex.mem_rd_en && (id_ex.rd != '0) &&
                  (id_ex.rd == rs1 || id_ex.rd == rs2);

   // taken branch kills if/id and id/ex
   assign flush = redirect.take;

   // operands of the instruction now in execute
   always_comb begin
      fwd_a = pick_fwd(id_ex.rs1, ex_mem, mem_wb);
      fwd_b = pick_fwd(id_ex.rs2, ex_mem, mem_wb);
   end

   // execute holds either a load or a branch, never both
   always_comb begin
      a_no_stall_in_flush : assert final (!(stall && flush))
         else $error("load-use stall during a branch flush");
   end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
// -----------------------------------------------
// 32 x 32 register file, two reads, one write
// -----------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module reg_file
   import dlx_isa_pkg::*;
   import dlx_pipe_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  reg_addr_t rd_addr_a,
   input  reg_addr_t rd_addr_b,
   output data_t     rd_data_a,
   output data_t     rd_data_b,
   input  wb_t       wb
);

   data_t regs [2**reg_addr_width];
   logic  wr_hit;

   // writes to r0 are discarded
   assign wr_hit = wb.wr_en && (wb.rd != '0);

   // all registers start at zero
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 2**reg_addr_width; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_hit) begin
         regs[wb.rd] <= wb.data;
      end
   end

   // same-cycle write shows on the read ports
   assign rd_data_a = (wr_hit && wb.rd == rd_addr_a) ? wb.data : regs[rd_addr_a];
   assign rd_data_b = (wr_hit && wb.rd == rd_addr_b) ? wb.data : regs[rd_addr_b];

   // r0 is never written by the write-back stage
   a_r0_zero : assert property (@(posedge clk) disable iff (!arst_n) regs[0] == '0)
      else $error("r0 storage changed");

endmodule

`default_nettype wire

// ==== design/write_back_stage.sv ====
// -----------------------------------------------
// mem/wb register and write-back data select
// -----------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module write_back_stage
   import dlx_isa_pkg::*;
   import dlx_pipe_pkg::*;
(
   input  logic    clk,
   input  logic    arst_n,
   input  ex_mem_t ex_mem,
   input  data_t   data_read,
   output mem_wb_t mem_wb,
   output wb_t     wb
);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mem_wb <= '0;
      end else begin
         mem_wb.alu_data   <= ex_mem.alu_data;
         mem_wb.rd         <= ex_mem.rd;
         mem_wb.reg_wr_en  <= ex_mem.reg_wr_en;
         mem_wb.mem_to_reg <= ex_mem.mem_rd_en;
      end
   end

   // load data returns one cycle after the address
   always_comb begin
      wb.rd    = mem_wb.rd;
      wb.wr_en = mem_wb.reg_wr_en;
      wb.data  = mem_wb.mem_to_reg ? data_read : mem_wb.alu_data;
   end

endmodule

`default_nettype wire
